// ==== logic/ddr_test_pkg.sv ====
package ddr_test_pkg;

  ////////////////////////////////////////////////////////////
  // memory port widths, same shape as the ddr3 user port
  ////////////////////////////////////////////////////////////
  localparam int byte_addr_w = 30;
  localparam int data_w      = 32;
  localparam int bl_w        = 6;   // word count minus one
  localparam int paddr_w     = 8;   // apb offset width

  // bit 0 of the mcb instr field
  localparam logic cmd_write = 1'b0;
  localparam logic cmd_read  = 1'b1;

  ////////////////////////////////////////////////////////////
  // host register map, byte offsets
  ////////////////////////////////////////////////////////////
  localparam logic [paddr_w-1:0] reg_addr   = 8'h00;
  localparam logic [paddr_w-1:0] reg_wdata  = 8'h04;
  localparam logic [paddr_w-1:0] reg_cmd    = 8'h08;  // bit 0 direction
  localparam logic [paddr_w-1:0] reg_rdata  = 8'h0C;
  localparam logic [paddr_w-1:0] reg_status = 8'h10;  // bit 0 busy, bit 1 rd valid

endpackage

// ==== logic/sram_port_ctrl.sv ====
module sram_port_ctrl
  import ddr_test_pkg::*;
#(
  parameter int mem_words  = 1024,
  parameter int rd_depth   = 16,
  parameter int access_lat = 3
) (
  input  logic                   clk_50m,
  input  logic                   sys_rst_i,
  input  logic                   cmd_en,
  input  logic                   cmd_rw,
  input  logic [bl_w-1:0]        cmd_bl,
  input  logic [byte_addr_w-1:0] cmd_byte_addr,
  output logic                   cmd_full,
  input  logic                   wr_en,
  input  logic [data_w-1:0]      wr_data,
  output logic                   wr_full,
  input  logic                   rd_en,
  output logic                   rd_empty,
  output logic [data_w-1:0]      rd_data
);
  localparam int aw  = $clog2(mem_words);
  localparam int raw = $clog2(rd_depth);
  localparam int lw  = $clog2(access_lat + 1);
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_turn = 2'd1;
  localparam logic [1:0] st_xfer = 2'd2;

  logic [data_w-1:0] mem [mem_words];

  logic              cq_rw   [4];   // command queue, 4 deep
  logic [bl_w-1:0]   cq_bl   [4];
  logic [aw-1:0]     cq_addr [4];
  logic [2:0]        cq_wp;
  logic [2:0]        cq_rp;
  logic              cq_empty;
  logic              cq_pop;

  logic [data_w-1:0] wq [4];        // write data queue
  logic [2:0]        wq_wp;
  logic [2:0]        wq_rp;
  logic              wq_empty;
  logic              wq_pop;

  logic [data_w-1:0] rq [rd_depth]; // read queue, fwft
  logic [raw:0]      rq_wp;
  logic [raw:0]      rq_rp;
  logic              rq_full;
  logic              rq_push;

  logic [1:0]        state;
  logic              exe_rw;
  logic [bl_w-1:0]   exe_left;      // words left minus one
  logic [aw-1:0]     exe_addr;
  logic [lw-1:0]     lat_cnt;
  logic              step;          // one word moves

  assign cmd_full = (cq_wp[2] != cq_rp[2]) && (cq_wp[1:0] == cq_rp[1:0]);
  assign cq_empty = cq_wp == cq_rp;
  assign wr_full  = (wq_wp[2] != wq_rp[2]) && (wq_wp[1:0] == wq_rp[1:0]);
  assign wq_empty = wq_wp == wq_rp;
  assign rq_full  = (rq_wp[raw] != rq_rp[raw]) && (rq_wp[raw-1:0] == rq_rp[raw-1:0]);
  assign rd_empty = rq_wp == rq_rp;
  assign rd_data  = rq[rq_rp[raw-1:0]];

  // read words hold here while the read queue is full
  assign step    = (state == st_xfer) && ((exe_rw == cmd_read) ? !rq_full : !wq_empty);
  assign cq_pop  = (state == st_idle) && !cq_empty;
  assign wq_pop  = step && (exe_rw == cmd_write);
  assign rq_push = step && (exe_rw == cmd_read);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_50m) begin
    if (cmd_en && !cmd_full) begin
      cq_rw[cq_wp[1:0]]   <= cmd_rw;
      cq_bl[cq_wp[1:0]]   <= cmd_bl;
      cq_addr[cq_wp[1:0]] <= cmd_byte_addr[aw+1:2];  // word addr, wraps at mem_words
    end
    if (wr_en && !wr_full) wq[wq_wp[1:0]] <= wr_data;
    if (rq_push) rq[rq_wp[raw-1:0]] <= mem[exe_addr];
    if (wq_pop) mem[exe_addr] <= wq[wq_rp[1:0]];
  end

  always_ff @(posedge clk_50m or negedge sys_rst_i) begin
    if (!sys_rst_i) begin
      cq_wp <= '0;
      cq_rp <= '0;
      wq_wp <= '0;
      wq_rp <= '0;
      rq_wp <= '0;
      rq_rp <= '0;
    end else begin
      if (cmd_en && !cmd_full) cq_wp <= cq_wp + 3'd1;
      if (cq_pop) cq_rp <= cq_rp + 3'd1;
      if (wr_en && !wr_full) wq_wp <= wq_wp + 3'd1;
      if (wq_pop) wq_rp <= wq_rp + 3'd1;
      if (rq_push) rq_wp <= rq_wp + 1'b1;
      if (rd_en && !rd_empty) rq_rp <= rq_rp + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // execute fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_50m or negedge sys_rst_i) begin
    if (!sys_rst_i) begin
      state    <= st_idle;
      exe_rw   <= cmd_write;
      exe_left <= '0;
      exe_addr <= '0;
      lat_cnt  <= '0;
    end else begin
      case (state)
        st_idle: if (cq_pop) begin
          exe_rw   <= cq_rw[cq_rp[1:0]];
          exe_left <= cq_bl[cq_rp[1:0]];
          exe_addr <= cq_addr[cq_rp[1:0]];
          lat_cnt  <= lw'(access_lat - 2);  // pop cycle is the first one
          state    <= st_turn;
        end
        st_turn: begin
          if (lat_cnt == '0) state <= st_xfer;
          else lat_cnt <= lat_cnt - 1'b1;
        end
        default: if (step) begin
          exe_addr <= exe_addr + 1'b1;
          exe_left <= exe_left - 1'b1;
          if (exe_left == '0) state <= st_idle;  // last word
        end
      endcase
    end
  end

endmodule

// ==== logic/port_arbiter.sv ====
module port_arbiter
  import ddr_test_pkg::*;
(
  input  logic                   clk_50m,
  input  logic                   sys_rst_i,
  input  logic                   h_cmd_req,
  input  logic                   h_cmd_rw,
  input  logic [bl_w-1:0]        h_cmd_bl,
  input  logic [byte_addr_w-1:0] h_cmd_byte_addr,
  output logic                   h_cmd_ack,
  input  logic                   h_rd_en,
  output logic                   h_rd_empty,
  input  logic                   f_cmd_req,
  input  logic [bl_w-1:0]        f_cmd_bl,
  input  logic [byte_addr_w-1:0] f_cmd_byte_addr,
  output logic                   f_cmd_ack,
  input  logic                   f_rd_en,
  output logic                   f_rd_empty,
  output logic                   m_cmd_en,
  output logic                   m_cmd_rw,
  output logic [bl_w-1:0]        m_cmd_bl,
  output logic [byte_addr_w-1:0] m_cmd_byte_addr,
  input  logic                   m_cmd_full,
  output logic                   m_rd_en,
  input  logic                   m_rd_empty
);
  localparam int tag_n = 4;  // reads in flight

  logic            rr_ptr;   // 1 favours the fetcher
  logic            grant_h;
  logic            grant_f;
  logic            tq_own [tag_n];  // 1 = fetcher
  logic [bl_w-1:0] tq_bl  [tag_n];
  logic [2:0]      tq_wp;
  logic [2:0]      tq_rp;
  logic            tq_empty;
  logic            tq_full;
  logic            tag_push;
  logic            head_own;
  logic [bl_w-1:0] word_cnt;        // words popped for head tag

  assign tq_empty = tq_wp == tq_rp;
  assign tq_full  = (tq_wp[2] != tq_rp[2]) && (tq_wp[1:0] == tq_rp[1:0]);

  // round robin, one command per cycle
  assign grant_h   = h_cmd_req && (!f_cmd_req || !rr_ptr);
  assign grant_f   = f_cmd_req && !grant_h;
  assign m_cmd_en  = (grant_h || grant_f) && !m_cmd_full && !tq_full;
  assign h_cmd_ack = grant_h && m_cmd_en;
  assign f_cmd_ack = grant_f && m_cmd_en;

  assign m_cmd_rw        = grant_h ? h_cmd_rw : cmd_read;  // fetcher only reads
  assign m_cmd_bl        = grant_h ? h_cmd_bl : f_cmd_bl;
  assign m_cmd_byte_addr = grant_h ? h_cmd_byte_addr : f_cmd_byte_addr;
  assign tag_push        = m_cmd_en && (m_cmd_rw == cmd_read);

  // only the head owner sees data
  assign head_own   = tq_own[tq_rp[1:0]];
  assign h_rd_empty = m_rd_empty || tq_empty || head_own;
  assign f_rd_empty = m_rd_empty || tq_empty || !head_own;
  assign m_rd_en    = head_own ? (f_rd_en && !f_rd_empty) : (h_rd_en && !h_rd_empty);

  always_ff @(posedge clk_50m) begin
    if (tag_push) begin
      tq_own[tq_wp[1:0]] <= grant_f;
      tq_bl[tq_wp[1:0]]  <= m_cmd_bl;
    end
  end

  always_ff @(posedge clk_50m or negedge sys_rst_i) begin
    if (!sys_rst_i) begin
      rr_ptr   <= 1'b0;
      tq_wp    <= '0;
      tq_rp    <= '0;
      word_cnt <= '0;
    end else begin
      if (m_cmd_en) rr_ptr <= grant_h;  // winner drops to low priority
      if (tag_push) tq_wp <= tq_wp + 3'd1;
      if (m_rd_en) begin
        if (word_cnt == tq_bl[tq_rp[1:0]]) begin
          word_cnt <= '0;  // last word, drop tag
          tq_rp    <= tq_rp + 3'd1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== logic/apb_mem_host.sv ====
module apb_mem_host
  import ddr_test_pkg::*;
(
  input  logic                   clk_50m,
  input  logic                   sys_rst_i,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [paddr_w-1:0]     paddr,
  input  logic [data_w-1:0]      pwdata,
  output logic [data_w-1:0]      prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   cmd_ack,
  output logic                   cmd_req,
  output logic                   cmd_rw,
  output logic [bl_w-1:0]        cmd_bl,
  output logic [byte_addr_w-1:0] cmd_byte_addr,
  output logic                   wr_en,
  output logic [data_w-1:0]      wr_data,
  input  logic                   wr_full,
  output logic                   rd_en,
  input  logic                   rd_empty,
  input  logic [data_w-1:0]      rd_data
);
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_push = 2'd1;  // write word into wr queue
  localparam logic [1:0] st_req  = 2'd2;
  localparam logic [1:0] st_wait = 2'd3;  // read word pending

  logic [1:0]             state;
  logic [byte_addr_w-1:0] addr_q;
  logic [data_w-1:0]      wdata_q;
  logic [data_w-1:0]      rdata_q;
  logic                   busy;
  logic                   rd_valid;
  logic                   access;
  logic                   known;
  logic                   wr_ok;
  logic                   start;

  ////////////////////////////////////////////////////////////
  // apb side, zero wait states
  ////////////////////////////////////////////////////////////
  assign access  = psel && penable;
  assign known   = paddr inside {reg_addr, reg_wdata, reg_cmd, reg_rdata, reg_status};
  assign pready  = 1'b1;
  assign pslverr = access && (!known || (pwrite && (paddr == reg_cmd) && busy));
  assign wr_ok   = access && pwrite && !pslverr;
  assign start   = wr_ok && (paddr == reg_cmd);

  always_comb begin
    case (paddr)
      reg_addr:   prdata = data_w'(addr_q);
      reg_wdata:  prdata = wdata_q;
      reg_rdata:  prdata = rdata_q;
      reg_status: prdata = data_w'({rd_valid, busy});
      default:    prdata = '0;  // reg_cmd reads as zero
    endcase
  end

  always_ff @(posedge clk_50m) begin
    if (wr_ok && (paddr == reg_addr)) addr_q <= pwdata[byte_addr_w-1:0];
    if (wr_ok && (paddr == reg_wdata)) wdata_q <= pwdata;
    if (start) begin
      cmd_byte_addr <= addr_q;  // frozen for the whole command
      wr_data       <= wdata_q;
    end
    if (rd_en) rdata_q <= rd_data;
  end

  ////////////////////////////////////////////////////////////
  // command engine
  ////////////////////////////////////////////////////////////
  assign cmd_req = state == st_req;
  assign cmd_bl  = '0;  // single word
  assign wr_en   = (state == st_push) && !wr_full;
  assign rd_en   = (state == st_wait) && !rd_empty;

  always_ff @(posedge clk_50m or negedge sys_rst_i) begin
    if (!sys_rst_i) begin
      state    <= st_idle;
      busy     <= 1'b0;
      rd_valid <= 1'b0;
      cmd_rw   <= cmd_write;
    end else begin
      case (state)
        st_idle: if (start) begin
          busy     <= 1'b1;
          rd_valid <= 1'b0;
          cmd_rw   <= pwdata[0];
          state    <= (pwdata[0] == cmd_read) ? st_req : st_push;
        end
        st_push: begin
          if (!wr_full) state <= st_req;  // data ahead of its command
        end
        st_req: if (cmd_ack) begin
          if (cmd_rw == cmd_read) begin
            state <= st_wait;
          end else begin
            busy  <= 1'b0;  // write handed off
            state <= st_idle;
          end
        end
        default: if (!rd_empty) begin
          rd_valid <= 1'b1;
          busy     <= 1'b0;
          state    <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== logic/line_fetch.sv ====
module line_fetch
  import ddr_test_pkg::*;
#(
  parameter int line_words  = 64,
  parameter int burst_words = 8,
  parameter int rd_depth    = 16
) (
  input  logic                   clk_50m,
  input  logic                   sys_rst_i,
  input  logic                   line_start,
  input  logic [byte_addr_w-1:0] line_base_addr,
  output logic                   line_busy,
  output logic                   cmd_req,
  input  logic                   cmd_ack,
  output logic [bl_w-1:0]        cmd_bl,
  output logic [byte_addr_w-1:0] cmd_byte_addr,
  output logic                   rd_en,
  input  logic                   rd_empty,
  input  logic [data_w-1:0]      rd_data,
  output logic                   pix_valid,
  output logic [data_w-1:0]      pix_data,
  input  logic                   pix_ready
);
  localparam int lw = $clog2(line_words + 1);
  localparam int pw = $clog2(rd_depth + burst_words + 1);

  logic [lw-1:0] req_left;  // words not yet requested
  logic [lw-1:0] pix_left;  // pixels not yet taken
  logic [pw-1:0] pend;      // requested, not popped
  logic          room;
  logic          take;

  assign cmd_bl = bl_w'(burst_words - 1);
  // one slot kept free for a host word
  assign room   = (pend + pw'(burst_words)) <= pw'(rd_depth - 1);
  assign rd_en  = !rd_empty && (!pix_valid || pix_ready);
  assign take   = pix_valid && pix_ready;

  always_ff @(posedge clk_50m) begin
    if (rd_en) pix_data <= rd_data;
  end

  always_ff @(posedge clk_50m or negedge sys_rst_i) begin
    if (!sys_rst_i) begin
      line_busy     <= 1'b0;
      cmd_req       <= 1'b0;
      cmd_byte_addr <= '0;
      pix_valid     <= 1'b0;
      req_left      <= '0;
      pix_left      <= '0;
      pend          <= '0;
    end else begin
      if (line_start && !line_busy) begin
        line_busy     <= 1'b1;
        req_left      <= lw'(line_words);
        pix_left      <= lw'(line_words);
        cmd_byte_addr <= line_base_addr;
      end
      if (cmd_ack) begin
        cmd_req       <= 1'b0;
        req_left      <= req_left - lw'(burst_words);
        cmd_byte_addr <= cmd_byte_addr + byte_addr_w'(burst_words * 4);
      end else if (line_busy && (req_left != '0) && room && !cmd_req) begin
        cmd_req <= 1'b1;
      end
      pend <= pend + (cmd_ack ? pw'(burst_words) : pw'(0)) - (rd_en ? pw'(1) : pw'(0));
      if (rd_en) pix_valid <= 1'b1;
      else if (take) pix_valid <= 1'b0;
      if (take) begin
        pix_left <= pix_left - 1'b1;
        if (pix_left == lw'(1)) line_busy <= 1'b0;  // last pixel gone
      end
    end
  end

endmodule

// ==== logic/ddr_test_top.sv ====
module ddr_test_top
  import ddr_test_pkg::*;
#(
  parameter int mem_words   = 1024,
  parameter int rd_depth    = 16,
  parameter int burst_words = 8,
  parameter int line_words  = 64,
  parameter int access_lat  = 3
) (
  input  logic                   clk_50m,
  input  logic                   sys_rst_i,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [paddr_w-1:0]     paddr,
  input  logic [data_w-1:0]      pwdata,
  output logic [data_w-1:0]      prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  logic                   line_start,
  input  logic [byte_addr_w-1:0] line_base_addr,
  output logic                   line_busy,
  output logic                   pix_valid,
  output logic [data_w-1:0]      pix_data,
  input  logic                   pix_ready
);
  ////////////////////////////////////////////////////////////
  // host, fetcher and controller port wires
  ////////////////////////////////////////////////////////////
  logic                   h_cmd_req, h_cmd_ack, h_cmd_rw, h_rd_en, h_rd_empty;
  logic [bl_w-1:0]        h_cmd_bl;
  logic [byte_addr_w-1:0] h_cmd_byte_addr;
  logic                   f_cmd_req, f_cmd_ack, f_rd_en, f_rd_empty;
  logic [bl_w-1:0]        f_cmd_bl;
  logic [byte_addr_w-1:0] f_cmd_byte_addr;
  logic                   m_cmd_en, m_cmd_rw, m_cmd_full, m_rd_en, m_rd_empty;
  logic [bl_w-1:0]        m_cmd_bl;
  logic [byte_addr_w-1:0] m_cmd_byte_addr;
  logic [data_w-1:0]      m_rd_data;   // shared by both readers
  logic                   wr_en, wr_full;  // host only
  logic [data_w-1:0]      wr_data;

  apb_mem_host u_host (
    .clk_50m, .sys_rst_i, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .cmd_ack(h_cmd_ack), .cmd_req(h_cmd_req), .cmd_rw(h_cmd_rw),
    .cmd_bl(h_cmd_bl), .cmd_byte_addr(h_cmd_byte_addr),
    .wr_en, .wr_data, .wr_full,
    .rd_en(h_rd_en), .rd_empty(h_rd_empty), .rd_data(m_rd_data)
  );

  line_fetch #(.line_words(line_words), .burst_words(burst_words), .rd_depth(rd_depth))
  u_fetch (
    .clk_50m, .sys_rst_i, .line_start, .line_base_addr, .line_busy,
    .cmd_req(f_cmd_req), .cmd_ack(f_cmd_ack), .cmd_bl(f_cmd_bl),
    .cmd_byte_addr(f_cmd_byte_addr),
    .rd_en(f_rd_en), .rd_empty(f_rd_empty), .rd_data(m_rd_data),
    .pix_valid, .pix_data, .pix_ready
  );

  port_arbiter u_arb (
    .clk_50m, .sys_rst_i,
    .h_cmd_req, .h_cmd_rw, .h_cmd_bl, .h_cmd_byte_addr, .h_cmd_ack, .h_rd_en, .h_rd_empty,
    .f_cmd_req, .f_cmd_bl, .f_cmd_byte_addr, .f_cmd_ack, .f_rd_en, .f_rd_empty,
    .m_cmd_en, .m_cmd_rw, .m_cmd_bl, .m_cmd_byte_addr, .m_cmd_full,
    .m_rd_en, .m_rd_empty
  );

  sram_port_ctrl #(.mem_words(mem_words), .rd_depth(rd_depth), .access_lat(access_lat))
  u_mem (
    .clk_50m, .sys_rst_i,
    .cmd_en(m_cmd_en), .cmd_rw(m_cmd_rw), .cmd_bl(m_cmd_bl),
    .cmd_byte_addr(m_cmd_byte_addr), .cmd_full(m_cmd_full),
    .wr_en, .wr_data, .wr_full,
    .rd_en(m_rd_en), .rd_empty(m_rd_empty), .rd_data(m_rd_data)
  );

endmodule

// ==== tb/tb_ddr_test.sv ====
module tb_ddr_test
  import ddr_test_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int mem_words  = 1024;
  localparam int line_words = 64;
  localparam int host_ops   = 40;    // write/read pairs in test 2
  localparam int share_rds  = 12;    // host reads under a running fetch
  localparam int wait_limit = 2000;  // cycles or polls per wait loop

  logic                   clk_50m;
  logic                   sys_rst_i;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [paddr_w-1:0]     paddr;
  logic [data_w-1:0]      pwdata;
  logic [data_w-1:0]      prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   line_start;
  logic [byte_addr_w-1:0] line_base_addr;
  logic                   line_busy;
  logic                   pix_valid;
  logic [data_w-1:0]      pix_data;
  logic                   pix_ready;

  integer      seed = 32'h0e63_0239;
  int          err_cnt = 0;
  int          test_cnt = 0;
  logic [31:0] ref_mem [mem_words];  // reference word array
  logic [31:0] pix_q [$];            // collected pixels
  bit          collect = 1'b0;
  bit          bp_on = 1'b0;         // random pix_ready when set
  bit          ready_next = 1'b1;    // next pix_ready, drawn at negedge

  ddr_test_top #(.mem_words(mem_words), .rd_depth(16), .burst_words(8),
                 .line_words(line_words), .access_lat(3)) dut0 (.*);

  initial clk_50m = 1'b0;
  always #10 clk_50m = ~clk_50m;  // 50 mhz

  always @(negedge clk_50m) begin
    ready_next = bp_on ? 1'($random(seed)) : 1'b1;
  end

  always @(posedge clk_50m) begin
    #2;
    pix_ready = ready_next;
  end

  // pix_ready is stable from +2 ns, so negedge sees the real handshake
  always @(negedge clk_50m) begin
    if (collect && pix_valid && pix_ready) pix_q.push_back(pix_data);
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_cnt++;
    $display("[FAIL] %s got %08h exp %08h", name, got, exp);
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic abort_run(input string msg);
    $display("timeout: %s", msg);
    $display("Test failures found");
    $finish;
  endtask

  function automatic int word_index(input logic [31:0] byte_addr);
    return int'((byte_addr >> 2) % mem_words);  // low two bits dropped
  endfunction

  ////////////////////////////////////////////////////////////
  // apb master, called at posedge + 2 ns
  ////////////////////////////////////////////////////////////
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    psel    = 1'b1;  // setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk_50m);
    #2;
    penable = 1'b1;  // access, zero waits
    @(negedge clk_50m);
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) report_mismatch("pready", 32'(pready), 32'h1);
    @(posedge clk_50m);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_xfer(1'b1, addr, data, unused, err);
    if (err !== 1'b0) report_mismatch("pslverr", 32'(err), 32'h0);
  endtask

  task automatic wait_idle(output logic [31:0] st);
    logic err;
    int   n = 0;
    do begin  // poll busy bit
      apb_xfer(1'b0, reg_status, 32'h0, st, err);
      n++;
      if (n > wait_limit) abort_run("host busy bit stayed high");
    end while (st[0]);
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] st;
    reg_write(reg_addr, addr);
    reg_write(reg_wdata, data);
    reg_write(reg_cmd, 32'(cmd_write));
    wait_idle(st);
    ref_mem[word_index(addr)] = data;
  endtask

  task automatic host_read_check(input logic [31:0] addr);
    logic [31:0] st;
    logic [31:0] rd;
    logic        err;
    reg_write(reg_addr, addr);
    reg_write(reg_cmd, 32'(cmd_read));
    wait_idle(st);
    if (st[1] !== 1'b1) report_mismatch("reg_status", st, 32'h2);
    apb_xfer(1'b0, reg_rdata, 32'h0, rd, err);
    if (rd !== ref_mem[word_index(addr)]) report_mismatch("reg_rdata", rd, ref_mem[word_index(addr)]);
  endtask

  ////////////////////////////////////////////////////////////
  // line fetch helpers
  ////////////////////////////////////////////////////////////
  task automatic fill_window(input logic [31:0] base);
    logic [31:0] a;
    for (int k = 0; k < line_words; k++) begin
      a = 32'(((word_index(base) + k) % mem_words) * 4);
      host_write(a, $random(seed));
    end
  endtask

  task automatic start_line(input logic [31:0] base);
    pix_q.delete();
    collect        = 1'b1;
    line_base_addr = base[byte_addr_w-1:0];
    line_start     = 1'b1;
    @(posedge clk_50m);
    #2;
    line_start = 1'b0;
  endtask

  task automatic finish_line(input logic [31:0] base);
    int n = 0;
    while (pix_q.size() < line_words || line_busy) begin
      @(posedge clk_50m);
      #2;
      n++;
      if (n > wait_limit) abort_run("line fetch did not complete");
    end
    collect = 1'b0;
    if (pix_q.size() != line_words) report_mismatch("pix_count", pix_q.size(), line_words);
    for (int k = 0; k < pix_q.size() && k < line_words; k++) begin
      if (pix_q[k] !== ref_mem[(word_index(base) + k) % mem_words])
        report_mismatch("pix_data", pix_q[k], ref_mem[(word_index(base) + k) % mem_words]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] base;
    logic [31:0] rd;
    logic        err;
    int          e0;
    sys_rst_i      = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    line_start     = 1'b0;
    line_base_addr = '0;
    pix_ready      = 1'b1;
    repeat (2) @(posedge clk_50m);
    #2;
    sys_rst_i = 1'b1;
    @(posedge clk_50m);
    #2;

    e0 = err_cnt;  // 1: reset state
    if (pix_valid !== 1'b0) report_mismatch("pix_valid", 32'(pix_valid), 32'h0);
    if (line_busy !== 1'b0) report_mismatch("line_busy", 32'(line_busy), 32'h0);
    apb_xfer(1'b0, reg_status, 32'h0, rd, err);
    if (rd !== 32'h0) report_mismatch("reg_status", rd, 32'h0);
    end_test("1 reset", e0);

    e0 = err_cnt;  // 2: single words, low bits differ on readback
    for (int i = 0; i < host_ops; i++) begin
      a = $random(seed) & 32'h3fff_ffff;
      host_write(a, $random(seed));
      host_read_check({a[31:2], 2'($random(seed))});
    end
    end_test("2 host access", e0);

    e0 = err_cnt;  // 3: plain line fetch
    base = $random(seed) & 32'h0000_0fe0;  // burst aligned
    fill_window(base);
    start_line(base);
    finish_line(base);
    end_test("3 line fetch", e0);

    e0 = err_cnt;  // 4: stalled pixels, host reads share the port
    base = $random(seed) & 32'h0000_0fe0;
    fill_window(base);
    bp_on = 1'b1;
    start_line(base);
    for (int i = 0; i < share_rds; i++)
      host_read_check(32'(((word_index(base) + ($random(seed) & 63)) % mem_words) * 4));
    finish_line(base);
    bp_on = 1'b0;
    end_test("4 back-pressure", e0);

    e0 = err_cnt;  // 5: slave errors
    a = 32'(((word_index(base) + 5) % mem_words) * 4);
    w = $random(seed);
    reg_write(reg_addr, a);
    reg_write(reg_wdata, w);
    reg_write(reg_cmd, 32'(cmd_read));
    apb_xfer(1'b1, reg_cmd, 32'(cmd_write), rd, err);  // still busy
    if (err !== 1'b1) report_mismatch("pslverr", 32'(err), 32'h1);
    apb_xfer(1'b1, 8'h14, $random(seed), rd, err);     // unknown offset
    if (err !== 1'b1) report_mismatch("pslverr", 32'(err), 32'h1);
    wait_idle(rd);
    apb_xfer(1'b0, reg_addr, 32'h0, rd, err);
    if (rd !== a) report_mismatch("reg_addr", rd, a);
    apb_xfer(1'b0, reg_wdata, 32'h0, rd, err);
    if (rd !== w) report_mismatch("reg_wdata", rd, w);
    apb_xfer(1'b0, reg_rdata, 32'h0, rd, err);
    if (rd !== ref_mem[word_index(a)]) report_mismatch("reg_rdata", rd, ref_mem[word_index(a)]);
    host_read_check(a);  // rejected write never reached memory
    end_test("5 errors", e0);

    $display("summary: %0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
logic/ddr_test_pkg.sv
logic/sram_port_ctrl.sv
logic/port_arbiter.sv
logic/apb_mem_host.sv
logic/line_fetch.sv
logic/ddr_test_top.sv
tb/tb_ddr_test.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory test subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f flist.f \
  --top-module tb_ddr_test \
  -Mdir obj_dir -o sim_ddr_test > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_ddr_test > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0
